// ==== common/sub_group_pkg.sv ====
// ------------------------------------------------
// Sub-group constants and vector types shared by
// the local interconnect and the tile banks
// ------------------------------------------------

package sub_group_pkg;

  // Masters and banks
  localparam int unsigned NumTiles    = 4;
  localparam int unsigned TileIdWidth = 2;

  // Words per bank are 2**RowWidth
  localparam int unsigned RowWidth    = 6;

  localparam int unsigned DataWidth   = 32;
  localparam int unsigned StrbWidth   = 4;

  typedef logic [TileIdWidth-1:0] tile_id_t;
  typedef logic [RowWidth-1:0]    row_addr_t;

  // Word address, bank index in the low bits
  typedef logic [TileIdWidth+RowWidth-1:0] tcdm_addr_t;

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

endpackage : sub_group_pkg

// ==== lic/lic_arbiter.sv ====
// ------------------------------------------------
// Per-bank round-robin arbiter of the local
// interconnect, also drives the master ready
// ------------------------------------------------

module lic_arbiter
  import sub_group_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic       [NumTiles-1:0] req_valid_i,
  input  tcdm_addr_t [NumTiles-1:0] req_addr_i,
  input  logic       [NumTiles-1:0] bank_ready_i,
  output logic       [NumTiles-1:0] bank_valid_o,
  output tile_id_t   [NumTiles-1:0] grant_o,
  output logic       [NumTiles-1:0] req_ready_o
);

  // Target bank of each master
  tile_id_t [NumTiles-1:0] tgt;

  for (genvar m = 0; m < NumTiles; m++) begin : gen_master
    assign tgt[m] = req_addr_i[m][TileIdWidth-1:0];
    assign req_ready_o[m] = bank_valid_o[tgt[m]] && bank_ready_i[tgt[m]] &&
                            (grant_o[tgt[m]] == tile_id_t'(m));
  end : gen_master

  for (genvar b = 0; b < NumTiles; b++) begin : gen_bank
    logic [NumTiles-1:0] match;
    tile_id_t            ptr_q;
    tile_id_t            grant;
    logic                valid;

    for (genvar m = 0; m < NumTiles; m++) begin : gen_match
      assign match[m] = req_valid_i[m] && (tgt[m] == tile_id_t'(b));
    end : gen_match

    // Walk down so the first requester at or after the pointer wins
    always_comb begin
      tile_id_t idx;
      grant = ptr_q;
      valid = 1'b0;
      for (int i = NumTiles - 1; i >= 0; i--) begin
        idx = tile_id_t'((int'(ptr_q) + i) % NumTiles);
        if (match[idx]) begin
          grant = idx;
          valid = 1'b1;
        end
      end
    end

    assign grant_o[b]      = grant;
    assign bank_valid_o[b] = valid;

    // Pointer moves one past the master that transferred
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        ptr_q <= '0;
      end else if (valid && bank_ready_i[b]) begin
        ptr_q <= (grant == tile_id_t'(NumTiles - 1)) ? '0 : grant + 1'b1;
      end
    end
  end : gen_bank

endmodule : lic_arbiter

// ==== lic/lic_req_mux.sv ====
// ------------------------------------------------
// Request mux. Forwards the granted master's fields
// to each bank with the initiator tag
// ------------------------------------------------

module lic_req_mux
  import sub_group_pkg::*;
(
  input  tcdm_addr_t [NumTiles-1:0] req_addr_i,
  input  logic       [NumTiles-1:0] req_wen_i,
  input  data_t      [NumTiles-1:0] req_wdata_i,
  input  strb_t      [NumTiles-1:0] req_be_i,
  input  tile_id_t   [NumTiles-1:0] grant_i,
  output row_addr_t  [NumTiles-1:0] bank_row_o,
  output logic       [NumTiles-1:0] bank_wen_o,
  output data_t      [NumTiles-1:0] bank_wdata_o,
  output strb_t      [NumTiles-1:0] bank_be_o,
  output tile_id_t   [NumTiles-1:0] bank_ini_o
);

  for (genvar b = 0; b < NumTiles; b++) begin : gen_bank
    tcdm_addr_t sel_addr;

    assign sel_addr = req_addr_i[grant_i[b]];

    // Bank bits dropped, only the row reaches the bank
    assign bank_row_o[b]   = sel_addr[TileIdWidth +: RowWidth];
    assign bank_wen_o[b]   = req_wen_i[grant_i[b]];
    assign bank_wdata_o[b] = req_wdata_i[grant_i[b]];
    assign bank_be_o[b]    = req_be_i[grant_i[b]];

    // Granted index travels as the initiator tag
    assign bank_ini_o[b]   = grant_i[b];
  end : gen_bank

endmodule : lic_req_mux

// ==== lic/lic_resp_xbar.sv ====
// ------------------------------------------------
// Response crossbar. Routes bank read data back to
// the tagged initiator, lowest bank index first
// ------------------------------------------------

module lic_resp_xbar
  import sub_group_pkg::*;
(
  input  logic     [NumTiles-1:0] bank_valid_i,
  input  tile_id_t [NumTiles-1:0] bank_ini_i,
  input  data_t    [NumTiles-1:0] bank_rdata_i,
  output logic     [NumTiles-1:0] bank_ready_o,
  output logic     [NumTiles-1:0] resp_valid_o,
  output data_t    [NumTiles-1:0] resp_rdata_o,
  input  logic     [NumTiles-1:0] resp_ready_i
);

  // Selected bank per master
  tile_id_t [NumTiles-1:0] sel;

  for (genvar m = 0; m < NumTiles; m++) begin : gen_master
    tile_id_t sel_bank;
    logic     found;

    // Walk down so the lowest matching bank wins
    always_comb begin
      sel_bank = '0;
      found    = 1'b0;
      for (int b = NumTiles - 1; b >= 0; b--) begin
        if (bank_valid_i[b] && (bank_ini_i[b] == tile_id_t'(m))) begin
          sel_bank = tile_id_t'(b);
          found    = 1'b1;
        end
      end
    end

    assign sel[m]          = sel_bank;
    assign resp_valid_o[m] = found;
    assign resp_rdata_o[m] = bank_rdata_i[sel_bank];
  end : gen_master

  // Drained only when picked and the master takes it
  for (genvar b = 0; b < NumTiles; b++) begin : gen_bank
    assign bank_ready_o[b] = bank_valid_i[b] && resp_ready_i[bank_ini_i[b]] &&
                             (sel[bank_ini_i[b]] == tile_id_t'(b));
  end : gen_bank

endmodule : lic_resp_xbar

// ==== rtl/tcdm_bank.sv ====
// ------------------------------------------------
// Tile memory bank with byte-enable writes and a
// registered read response
// ------------------------------------------------

module tcdm_bank
  import sub_group_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      valid_i,
  input  logic      wen_i,
  input  row_addr_t row_i,
  input  data_t     wdata_i,
  input  strb_t     be_i,
  input  tile_id_t  ini_i,
  output logic      ready_o,
  output logic      out_valid_o,
  output tile_id_t  out_ini_o,
  output data_t     out_rdata_o,
  input  logic      out_ready_i
);

  localparam int unsigned ByteWidth = DataWidth / StrbWidth;

  data_t    mem_q [2**RowWidth];
  logic     out_valid_q;
  tile_id_t out_ini_q;
  data_t    out_rdata_q;
  logic     wr_acc;
  logic     rd_acc;

  // Free when empty or drained this cycle
  assign ready_o = !out_valid_q || out_ready_i;
  assign wr_acc  = valid_i && ready_o && wen_i;
  assign rd_acc  = valid_i && ready_o && !wen_i;

  // ------------------------------------------------
  // Storage and response payload
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (wr_acc) begin
      for (int i = 0; i < StrbWidth; i++) begin
        if (be_i[i]) begin
          mem_q[row_i][i*ByteWidth +: ByteWidth] <= wdata_i[i*ByteWidth +: ByteWidth];
        end
      end
    end
    if (rd_acc) begin
      out_rdata_q <= mem_q[row_i];
      out_ini_q   <= ini_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (rd_acc) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_ini_o   = out_ini_q;
  assign out_rdata_o = out_rdata_q;

endmodule : tcdm_bank

// ==== rtl/sub_group_top.sv ====
// ------------------------------------------------
// Sub-group top. Local interconnect between the
// core-side request ports and the tile banks
// ------------------------------------------------

module sub_group_top
  import sub_group_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Master requests
  input  logic       [NumTiles-1:0] req_valid_i,
  output logic       [NumTiles-1:0] req_ready_o,
  input  tcdm_addr_t [NumTiles-1:0] req_addr_i,
  input  logic       [NumTiles-1:0] req_wen_i,
  input  data_t      [NumTiles-1:0] req_wdata_i,
  input  strb_t      [NumTiles-1:0] req_be_i,
  // Master responses
  output logic       [NumTiles-1:0] resp_valid_o,
  input  logic       [NumTiles-1:0] resp_ready_i,
  output data_t      [NumTiles-1:0] resp_rdata_o
);

  // Bank request side
  logic      [NumTiles-1:0] bank_valid;
  logic      [NumTiles-1:0] bank_ready;
  tile_id_t  [NumTiles-1:0] bank_grant;
  row_addr_t [NumTiles-1:0] bank_row;
  logic      [NumTiles-1:0] bank_wen;
  data_t     [NumTiles-1:0] bank_wdata;
  strb_t     [NumTiles-1:0] bank_be;
  tile_id_t  [NumTiles-1:0] bank_ini;

  // Bank response side
  logic      [NumTiles-1:0] out_valid;
  logic      [NumTiles-1:0] out_ready;
  tile_id_t  [NumTiles-1:0] out_ini;
  data_t     [NumTiles-1:0] out_rdata;

  lic_arbiter i_arbiter (
    .clk_i       (clk_i      ),
    .arst_n_i    (arst_n_i   ),
    .req_valid_i (req_valid_i),
    .req_addr_i  (req_addr_i ),
    .bank_ready_i(bank_ready ),
    .bank_valid_o(bank_valid ),
    .grant_o     (bank_grant ),
    .req_ready_o (req_ready_o)
  );

  lic_req_mux i_req_mux (
    .req_addr_i  (req_addr_i ),
    .req_wen_i   (req_wen_i  ),
    .req_wdata_i (req_wdata_i),
    .req_be_i    (req_be_i   ),
    .grant_i     (bank_grant ),
    .bank_row_o  (bank_row   ),
    .bank_wen_o  (bank_wen   ),
    .bank_wdata_o(bank_wdata ),
    .bank_be_o   (bank_be    ),
    .bank_ini_o  (bank_ini   )
  );

  for (genvar b = 0; b < NumTiles; b++) begin : gen_banks
    tcdm_bank i_bank (
      .clk_i      (clk_i        ),
      .arst_n_i   (arst_n_i     ),
      .valid_i    (bank_valid[b]),
      .wen_i      (bank_wen[b]  ),
      .row_i      (bank_row[b]  ),
      .wdata_i    (bank_wdata[b]),
      .be_i       (bank_be[b]   ),
      .ini_i      (bank_ini[b]  ),
      .ready_o    (bank_ready[b]),
      .out_valid_o(out_valid[b] ),
      .out_ini_o  (out_ini[b]   ),
      .out_rdata_o(out_rdata[b] ),
      .out_ready_i(out_ready[b] )
    );
  end : gen_banks

  lic_resp_xbar i_resp_xbar (
    .bank_valid_i(out_valid   ),
    .bank_ini_i  (out_ini     ),
    .bank_rdata_i(out_rdata   ),
    .bank_ready_o(out_ready   ),
    .resp_valid_o(resp_valid_o),
    .resp_rdata_o(resp_rdata_o),
    .resp_ready_i(resp_ready_i)
  );

endmodule : sub_group_top

// ==== testbench/tb_clk_gen.sv ====
// ------------------------------------------------
// Testbench clock and reset generator
// ------------------------------------------------

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset held for 3 cycles, released on a falling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule : tb_clk_gen

// ==== testbench/sub_group_chk.sv ====
// ------------------------------------------------
// Handshake assertions bound into the sub-group top
// ------------------------------------------------

module sub_group_chk
  import sub_group_pkg::*;
(
  input logic                      clk_i,
  input logic                      arst_n_i,
  input logic       [NumTiles-1:0] req_ready_i,
  input tcdm_addr_t [NumTiles-1:0] req_addr_i,
  input logic       [NumTiles-1:0] resp_valid_i,
  input logic       [NumTiles-1:0] resp_ready_i,
  input data_t      [NumTiles-1:0] resp_rdata_i,
  input logic       [NumTiles-1:0] out_valid_i
);

  for (genvar m = 0; m < NumTiles; m++) begin : gen_master
    // Stalled response keeps valid and data
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      resp_valid_i[m] && !resp_ready_i[m] |=> resp_valid_i[m] && $stable(resp_rdata_i[m]))
      else $error("response to master %0d dropped or changed while stalled", m);

    // One ready master per bank
    for (genvar n = m + 1; n < NumTiles; n++) begin : gen_pair
      assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(req_ready_i[m] && req_ready_i[n] &&
          (req_addr_i[m][TileIdWidth-1:0] == req_addr_i[n][TileIdWidth-1:0])))
        else $error("masters %0d and %0d both ready for one bank", m, n);
    end : gen_pair
  end : gen_master

  assert property (@(posedge clk_i) !arst_n_i |-> (out_valid_i == '0))
    else $error("bank response valid during reset");

endmodule : sub_group_chk

bind sub_group_top sub_group_chk i_chk (
  .clk_i       (clk_i       ),
  .arst_n_i    (arst_n_i    ),
  .req_ready_i (req_ready_o ),
  .req_addr_i  (req_addr_i  ),
  .resp_valid_i(resp_valid_o),
  .resp_ready_i(resp_ready_i),
  .resp_rdata_i(resp_rdata_o),
  .out_valid_i (out_valid   )
);

// ==== testbench/tb_sub_group.sv ====
// ------------------------------------------------
// Testbench for the sub-group interconnect and banks
// ------------------------------------------------

module tb_sub_group
  import sub_group_pkg::*;
();

  localparam int Timeout = 200;
  localparam int NumStim = 15;
  localparam int RandOps = 40;
  localparam int HoldCyc = 5;
  localparam int ByteW   = DataWidth / StrbWidth;

  typedef struct packed {
    tile_id_t   master;
    tcdm_addr_t addr;
    logic       wen;
    data_t      data;
    strb_t      be;
    data_t      exp;
  } stim_t;

  logic                      clk;
  logic                      arst_n;
  logic       [NumTiles-1:0] req_valid;
  logic       [NumTiles-1:0] req_ready;
  tcdm_addr_t [NumTiles-1:0] req_addr;
  logic       [NumTiles-1:0] req_wen;
  data_t      [NumTiles-1:0] req_wdata;
  strb_t      [NumTiles-1:0] req_be;
  logic       [NumTiles-1:0] resp_valid;
  logic       [NumTiles-1:0] resp_ready;
  data_t      [NumTiles-1:0] resp_rdata;

  // Reference model of all banks, indexed by word address
  data_t       model [2**(TileIdWidth+RowWidth)];
  stim_t       stim [NumStim];
  logic [31:0] lcg_st [NumTiles];
  int          checks;
  int          errors;
  int          test_err;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk   ),
    .arst_n_o(arst_n)
  );

  sub_group_top uut (
    .clk_i       (clk       ),
    .arst_n_i    (arst_n    ),
    .req_valid_i (req_valid ),
    .req_ready_o (req_ready ),
    .req_addr_i  (req_addr  ),
    .req_wen_i   (req_wen   ),
    .req_wdata_i (req_wdata ),
    .req_be_i    (req_be    ),
    .resp_valid_o(resp_valid),
    .resp_ready_i(resp_ready),
    .resp_rdata_o(resp_rdata)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t be);
    data_t res;
    res = old;
    for (int i = 0; i < StrbWidth; i++) begin
      if (be[i]) begin
        res[i*ByteW +: ByteW] = wdata[i*ByteW +: ByteW];
      end
    end
    return res;
  endfunction

  task automatic compare(input logic [63:0] act, input logic [63:0] exp, input string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR at time %0t: %s, got %0h expected %0h", $time, what, act, exp);
    end
  endtask

  task automatic abort_run(input string what);
    $display("Timeout: %s did not happen within %0d cycles", what, Timeout);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic finish_test(input string name);
    $display("Test %s: %s", name, (errors == test_err) ? "passed" : "FAILED");
    test_err = errors;
  endtask

  // One request from master m, read data checked against the model
  task automatic do_access(input int m, input tcdm_addr_t addr, input logic wen,
                           input data_t wdata, input strb_t be,
                           output data_t rdata, output int wait_cyc, output int lat);
    data_t exp;
    rdata    = '0;
    exp      = '0;
    wait_cyc = 0;
    lat      = 0;
    @(negedge clk);
    req_addr[m]  = addr;
    req_wen[m]   = wen;
    req_wdata[m] = wdata;
    req_be[m]    = be;
    req_valid[m] = 1'b1;
    #1;
    while (!req_ready[m]) begin
      wait_cyc++;
      if (wait_cyc > Timeout) begin
        abort_run("request acceptance");
      end
      @(negedge clk);
      #1;
    end
    @(posedge clk);
    if (wen) begin
      model[addr] = merge_bytes(model[addr], wdata, be);
    end else begin
      exp = model[addr];
    end
    @(negedge clk);
    req_valid[m] = 1'b0;
    if (!wen) begin
      lat = 1;
      #1;
      while (!(resp_valid[m] && resp_ready[m])) begin
        lat++;
        if (lat > Timeout) begin
          abort_run("read response");
        end
        @(negedge clk);
        #1;
      end
      rdata = resp_rdata[m];
      @(posedge clk);
      compare(rdata, exp, "read data against model");
    end
  endtask

  task automatic wait_resp_valid(input int m);
    int cnt;
    cnt = 0;
    while (!resp_valid[m]) begin
      cnt++;
      if (cnt > Timeout) begin
        abort_run("response valid");
      end
      @(negedge clk);
      #1;
    end
  endtask

  task automatic load_table();
    // master, address, write, data, byte enables, expected read data
    stim[0]  = '{2'd0, 8'h10, 1'b1, 32'h1234_5678, 4'hf, 32'h0};
    stim[1]  = '{2'd0, 8'h10, 1'b0, 32'h0, 4'h0, 32'h1234_5678};
    // Byte merge on one word of bank 1
    stim[2]  = '{2'd1, 8'h25, 1'b1, 32'haabb_ccdd, 4'hf, 32'h0};
    stim[3]  = '{2'd1, 8'h25, 1'b1, 32'h1122_3344, 4'h1, 32'h0};
    stim[4]  = '{2'd1, 8'h25, 1'b1, 32'h5566_7788, 4'h6, 32'h0};
    stim[5]  = '{2'd1, 8'h25, 1'b1, 32'h9900_0000, 4'h8, 32'h0};
    stim[6]  = '{2'd1, 8'h25, 1'b0, 32'h0, 4'h0, 32'h9966_7744};
    // Consecutive words span banks 0 to 3
    stim[7]  = '{2'd0, 8'h40, 1'b1, 32'ha0a0_0001, 4'hf, 32'h0};
    stim[8]  = '{2'd0, 8'h41, 1'b1, 32'hb1b1_0002, 4'hf, 32'h0};
    stim[9]  = '{2'd0, 8'h42, 1'b1, 32'hc2c2_0003, 4'hf, 32'h0};
    stim[10] = '{2'd0, 8'h43, 1'b1, 32'hd3d3_0004, 4'hf, 32'h0};
    stim[11] = '{2'd3, 8'h40, 1'b0, 32'h0, 4'h0, 32'ha0a0_0001};
    stim[12] = '{2'd3, 8'h41, 1'b0, 32'h0, 4'h0, 32'hb1b1_0002};
    stim[13] = '{2'd3, 8'h42, 1'b0, 32'h0, 4'h0, 32'hc2c2_0003};
    stim[14] = '{2'd3, 8'h43, 1'b0, 32'h0, 4'h0, 32'hd3d3_0004};
  endtask

  task automatic run_table(input int lo, input int hi);
    data_t rdata;
    int    w;
    int    l;
    for (int i = lo; i <= hi; i++) begin
      do_access(int'(stim[i].master), stim[i].addr, stim[i].wen, stim[i].data,
                stim[i].be, rdata, w, l);
      if (!stim[i].wen) begin
        compare(rdata, stim[i].exp, "table read data");
        compare(l, 1, "read latency");
      end
    end
  endtask

  task automatic fill_bank(input int b);
    tcdm_addr_t addr;
    data_t      rdata;
    int         w;
    int         l;
    for (int r = 0; r < 2**RowWidth; r++) begin
      addr = tcdm_addr_t'((r << TileIdWidth) | b);
      do_access(b, addr, 1'b1, {addr, ~addr, addr ^ 8'h5a, addr + 8'h33}, 4'hf, rdata, w, l);
    end
  endtask

  task automatic random_traffic(input int m);
    tcdm_addr_t addr;
    logic       wen;
    data_t      rdata;
    int         w;
    int         l;
    for (int i = 0; i < RandOps; i++) begin
      lcg_st[m] = lcg_next(lcg_st[m]);
      addr      = lcg_st[m][23:16];
      wen       = lcg_st[m][29];
      lcg_st[m] = lcg_next(lcg_st[m]);
      do_access(m, addr, wen, lcg_st[m], lcg_st[m][27:24], rdata, w, l);
    end
  endtask

  initial begin
    int    w [NumTiles];
    int    l [NumTiles];
    data_t rd [NumTiles];
    int    cnt;
    req_valid  = '0;
    req_addr   = '0;
    req_wen    = '0;
    req_wdata  = '0;
    req_be     = '0;
    resp_ready = '1;
    checks     = 0;
    errors     = 0;
    test_err   = 0;
    lcg_st[0]  = 32'd45876;
    for (int m = 1; m < NumTiles; m++) begin
      lcg_st[m] = lcg_next(lcg_st[m-1]);
    end
    load_table();
    cnt = 0;
    while (arst_n !== 1'b1) begin
      cnt++;
      if (cnt > Timeout) begin
        abort_run("reset release");
      end
      @(negedge clk);
    end

    compare(resp_valid, '0, "resp_valid after reset");
    run_table(0, 1);
    finish_test("1 after reset");
    run_table(2, 6);
    finish_test("2 byte enables");
    run_table(7, 14);
    finish_test("3 interleaving");

    // All masters read bank 2 at once
    // Master 0 writes last, so bank 2 grants from master 1 on
    for (int m = NumTiles - 1; m >= 0; m--) begin
      do_access(m, tcdm_addr_t'(8'h82 + 4 * m), 1'b1, 32'h5100_0000 + m, 4'hf,
                rd[m], w[m], l[m]);
    end
    fork
      do_access(0, 8'h82, 1'b0, '0, '0, rd[0], w[0], l[0]);
      do_access(1, 8'h86, 1'b0, '0, '0, rd[1], w[1], l[1]);
      do_access(2, 8'h8a, 1'b0, '0, '0, rd[2], w[2], l[2]);
      do_access(3, 8'h8e, 1'b0, '0, '0, rd[3], w[3], l[3]);
    join
    for (int m = 0; m < NumTiles; m++) begin
      compare(w[m], (m + NumTiles - 1) % NumTiles, "accept wait under contention");
    end
    finish_test("4 contention");

    do_access(0, 8'h07, 1'b1, 32'h7777_0707, 4'hf, rd[0], w[0], l[0]);
    do_access(0, 8'h0b, 1'b1, 32'hbbbb_0b0b, 4'hf, rd[0], w[0], l[0]);
    @(negedge clk);
    resp_ready[1] = 1'b0;
    fork
      do_access(1, 8'h07, 1'b0, '0, '0, rd[1], w[1], l[1]);
      begin
        wait_resp_valid(1);
        do_access(2, 8'h0b, 1'b0, '0, '0, rd[2], w[2], l[2]);
      end
      begin
        wait_resp_valid(1);
        for (int i = 0; i < HoldCyc; i++) begin
          @(negedge clk);
          #1;
          compare(resp_valid[1], 1'b1, "held resp_valid");
          compare(resp_rdata[1], model[8'h07], "held resp_rdata");
          compare(req_ready[2], 1'b0, "stalled req_ready");
        end
        @(negedge clk);
        resp_ready[1] = 1'b1;
      end
    join
    compare(w[2] >= HoldCyc, 1'b1, "stall length");
    finish_test("5 back-pressure");

    fork
      fill_bank(0);
      fill_bank(1);
      fill_bank(2);
      fill_bank(3);
    join
    fork
      random_traffic(0);
      random_traffic(1);
      random_traffic(2);
      random_traffic(3);
    join
    finish_test("6 random traffic");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_sub_group

// ==== files.f ====
common/sub_group_pkg.sv
lic/lic_arbiter.sv
lic/lic_req_mux.sv
lic/lic_resp_xbar.sv
rtl/tcdm_bank.sv
rtl/sub_group_top.sv
testbench/tb_clk_gen.sv
testbench/sub_group_chk.sv
testbench/tb_sub_group.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the sub-group testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_sub_group \
  -f files.f -o sim_sub_group \
  && ./obj_dir/sim_sub_group > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "FAIL: no pass line"; exit 1; }
echo "PASS"
